//--- Makefile
# Verilator build, run and lint for the info link testbench

TOP := info_link_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

obj_dir/V$(TOP): project.f verilog/*.sv verilog/*.svh sim/*.sv
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- project.f
+incdir+verilog
verilog/info_link_pkg.sv
verilog/info_link_if.sv
verilog/tx_byte_queue.sv
verilog/tx_info_phy.sv
verilog/rx_info_phy.sv
verilog/info_link_top.sv
sim/info_link_asserts.sv
sim/info_link_tb.sv

//--- sim/info_link_asserts.sv
// protocol checks on the queue to PHY hand-off and the receive outputs

module info_link_asserts (
	input logic clk_sys,
	input logic rst_n,
	input logic fire,
	input logic done,
	input logic busy,
	input logic line_out,
	input logic rx_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	int   fail_count = 0;
	logic in_flight;

	// frame in flight from fire until the PHY's done
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			in_flight <= 1'b0;
		end else if (fire) begin
			in_flight <= 1'b1;
		end else if (done) begin
			in_flight <= 1'b0;
		end
	end

	fire_when_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		fire |-> !in_flight)
		else begin
			$error("fire raised while a frame is outstanding");
			fail_count++;
		end

	done_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		done |=> !done)
		else begin
			$error("done held for more than one cycle");
			fail_count++;
		end

	// nothing queued and nothing in flight
	line_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!busy |-> line_out)
		else begin
			$error("line low while the link is not busy");
			fail_count++;
		end

	rx_valid_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rx_valid |=> !rx_valid)
		else begin
			$error("rx_valid held for more than one cycle");
			fail_count++;
		end

endmodule

bind info_link_top info_link_asserts u_asserts (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.fire     (link.fire),
	.done     (link.done),
	.busy     (busy),
	.line_out (line_out),
	.rx_valid (rx_valid)
);

//--- sim/info_link_tb.sv
// info link testbench, trace driven loopback, frame injection and random traffic

`include "info_link_params.svh"

module info_link_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TRACE_WORDS = 128;
	localparam int REC_W = 8;
	localparam int MAX_GAP = 12;

	logic                        clk_sys;
	logic                        rst_n;
	info_link_pkg::info_period_t tbit_period;
	logic                        push;
	info_link_pkg::info_byte_t   push_data;
	logic                        line_in;
	logic                        full;
	logic                        busy;
	logic                        line_out;
	info_link_pkg::info_byte_t   rx_data;
	logic                        rx_valid;
	logic                        rx_frame_err;
	logic                        loop_mode;
	logic                        inj_line;

	logic [31:0]               trace_mem [TRACE_WORDS];
	info_link_pkg::info_byte_t got_data [$];
	logic                      got_err [$];
	logic                      busy_at_valid;
	int                        errors = 0;
	int                        cycles = 0;
	int                        cycle_limit = 0;

	assign line_in = loop_mode ? line_out : inj_line;

	info_link_top uut (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.tbit_period  (tbit_period),
		.push         (push),
		.push_data    (push_data),
		.line_in      (line_in),
		.full         (full),
		.busy         (busy),
		.line_out     (line_out),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_frame_err (rx_frame_err)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// receive monitor on the falling edge
	always @(negedge clk_sys) begin
		if (rx_valid) begin
			got_data.push_back(rx_data);
			got_err.push_back(rx_frame_err);
			busy_at_valid = busy;
		end
	end

	task automatic tick();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic check_value(input logic ok, input string what);
		assert (ok) else begin
			$display("MISMATCH at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic push_byte(input info_link_pkg::info_byte_t b);
		while (full) tick();
		push = 1'b1;
		push_data = b;
		tick();
		push = 1'b0;
	endtask

	task automatic wait_received(input int n);
		while (got_data.size() < n) @(negedge clk_sys);
	endtask

	task automatic wait_idle();
		while (busy) tick();
		repeat (4) tick();
	endtask

	// ----------------------------------------------------------
	// start bit follows fire by one cycle and lasts one period
	// ----------------------------------------------------------
	task automatic watch_start_bit(input info_link_pkg::info_byte_t b, input int p);
		int low_cnt;
		low_cnt = 0;
		repeat (2) @(negedge clk_sys);
		check_value(line_out, "line left idle before the first fire");
		for (int i = 0; i < p; i++) begin
			@(negedge clk_sys);
			if (!line_out) low_cnt++;
		end
		check_value(low_cnt == p, $sformatf("start bit low for %0d of %0d cycles", low_cnt, p));
		@(negedge clk_sys);
		check_value(line_out == b[7], "first data bit after the start bit is not the MSB");
	endtask

	task automatic compare_bytes(input int first, input info_link_pkg::info_byte_t exp_q[$]);
		check_value(got_data.size() == first + exp_q.size(),
			$sformatf("received %0d bytes, expected %0d", got_data.size() - first, exp_q.size()));
		foreach (exp_q[i]) begin
			if (first + i < got_data.size()) begin
				check_value(got_data[first + i] == exp_q[i], $sformatf("byte %0d got %h expected %h",
					i, got_data[first + i], exp_q[i]));
				check_value(!got_err[first + i], $sformatf("byte %0d flagged a frame error", i));
			end
		end
	endtask

	task automatic inject_frame(input logic [9:0] bits, input int p);
		for (int i = 9; i >= 0; i--) begin
			inj_line = bits[i];
			repeat (p) tick();
		end
		inj_line = 1'b1;
	endtask

	initial begin
		int base;
		int kind;
		int p;
		int arg;
		int first;
		int err_before;
		int tests;
		int tests_failed;
		int gap;
		info_link_pkg::info_byte_t exp_q[$];
		info_link_pkg::info_byte_t b;

		rst_n = 1'b0;
		push = 1'b0;
		push_data = '0;
		tbit_period = info_link_pkg::info_period_t'(4);
		loop_mode = 1'b1;
		inj_line = 1'b1;
		tests = 0;
		tests_failed = 0;
		void'($urandom(60258));
		$readmemh("sim/info_link_trace.txt", trace_mem);

		// run length from the trace with slack per record
		cycle_limit = 16 + 200;
		base = 0;
		while (base < TRACE_WORDS && trace_mem[base] != 32'hf) begin
			p = int'(trace_mem[base + 1]);
			arg = int'(trace_mem[base + 2]);
			case (int'(trace_mem[base]))
				0: cycle_limit += arg * (13 * p + 2);
				1: cycle_limit += 11 * p;
				2: cycle_limit += 11 * p + arg;
				default: cycle_limit += arg * (13 * p + 2 + MAX_GAP);
			endcase
			cycle_limit += 20;
			base += REC_W;
		end

		repeat (16) @(posedge clk_sys);
		#5;
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_value(line_out && !busy && !rx_valid && !rx_frame_err, "outputs wrong after reset");
		$display("test 0 reset: %s", (errors == 0) ? "ok" : "failed");
		if (errors != 0) tests_failed++;
		tests++;
		tick();

		base = 0;
		while (base < TRACE_WORDS && trace_mem[base] != 32'hf) begin
			kind = int'(trace_mem[base]);
			p = int'(trace_mem[base + 1]);
			arg = int'(trace_mem[base + 2]);
			err_before = errors;
			first = got_data.size();
			exp_q.delete();
			tbit_period = info_link_pkg::info_period_t'(p);
			tick();
			case (kind)
				0: begin
					for (int i = 0; i < arg; i++) exp_q.push_back(trace_mem[base + 3 + i][7:0]);
					fork
						begin
							foreach (exp_q[i]) push_byte(exp_q[i]);
							if (arg > `INFO_QUEUE_DEPTH) check_value(full, "full not set by the burst");
						end
						watch_start_bit(exp_q[0], p);
					join
					wait_received(first + arg);
					check_value(busy_at_valid, "busy fell before the last rx_valid");
					wait_idle();
					compare_bytes(first, exp_q);
				end
				1: begin
					loop_mode = 1'b0;
					inject_frame(arg[9:0], p);
					wait_received(first + 1);
					repeat (4) tick();
					check_value(got_data.size() == first + 1, "injected frame not received once");
					check_value(got_data[first] == trace_mem[base + 3][7:0],
						$sformatf("injected byte got %h", got_data[first]));
					check_value(got_err[first] == trace_mem[base + 4][0], "frame error flag wrong");
					loop_mode = 1'b1;
				end
				2: begin
					loop_mode = 1'b0;
					inj_line = 1'b0;
					repeat (arg) tick();
					inj_line = 1'b1;
					// long enough for a whole frame to come out
					repeat (11 * p) tick();
					check_value(got_data.size() == first, "start glitch produced rx_valid");
					loop_mode = 1'b1;
				end
				default: begin
					for (int i = 0; i < arg; i++) begin
						gap = $urandom % MAX_GAP;
						repeat (gap) tick();
						b = info_link_pkg::info_byte_t'($urandom);
						exp_q.push_back(b);
						push_byte(b);
					end
					wait_received(first + arg);
					wait_idle();
					compare_bytes(first, exp_q);
				end
			endcase
			tests++;
			if (errors != err_before) tests_failed++;
			$display("test %0d kind %0d period %0d: %s", tests - 1, kind, p,
				(errors == err_before) ? "ok" : "failed");
			base += REC_W;
		end

		errors += uut.u_asserts.fail_count;
		$display("tests run %0d, tests failed %0d, failed checks %0d", tests, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- sim/info_link_trace.txt
// kind period arg w3 w4 w5 w6 w7, all hex; kind 0 loopback (arg bytes, w3.. data), 1 inject
// (arg = start, data MSB first, stop; w3 data, w4 error), 2 glitch (arg low cycles), 3 random, f end
0 00004 1 a5 00 00 00 00
0 00007 1 3c 00 00 00 00
0 00010 1 81 00 00 00 00
// burst, one more than the queue holds after the first pop
0 00006 5 11 e2 33 c4 55
1 00008 0b4 5a 1 00 00 00
1 00008 187 c3 0 00 00 00
2 00010 3 00 00 00 00 00
3 00005 8 00 00 00 00 00
3 0000c 6 00 00 00 00 00
f 00000 0 00 00 00 00 00

//--- verilog/info_link_if.sv
// byte hand-off between the transmit queue and the transmit PHY

interface info_link_if;

	// byte to send, valid while fire is high
	info_link_pkg::info_byte_t data;

	// one-cycle start strobe from the queue
	logic fire;

	// one-cycle end of frame strobe from the PHY
	logic done;

	// bit period, passed through from the top level
	info_link_pkg::info_period_t period;

	modport queue (
		output data,
		output fire,
		output period,
		input  done
	);

	modport phy (
		input  data,
		input  fire,
		input  period,
		output done
	);

endinterface

//--- verilog/info_link_params.svh
// info link shared widths, transmit queue depth and stop bit count

`ifndef INFO_LINK_PARAMS_SVH
`define INFO_LINK_PARAMS_SVH

// one data byte on the line
`define INFO_DATA_W 8

// bit period setting, in clk_sys cycles
`define INFO_PERIOD_W 20

// transmit queue entries, power of two
`define INFO_QUEUE_DEPTH 4

// stop bits sent per frame
// the receiver checks only the first
`define INFO_STOP_BITS 4

`endif

//--- verilog/info_link_pkg.sv
// info link types shared by the queue, the transmit PHY and the receive PHY

`include "info_link_params.svh"

package info_link_pkg;

	typedef logic [`INFO_DATA_W-1:0] info_byte_t;

	typedef logic [`INFO_PERIOD_W-1:0] info_period_t;

	// one extra bit to tell full from empty
	typedef logic [$clog2(`INFO_QUEUE_DEPTH):0] queue_ptr_t;

	// ----------------------------------------------------------
	// state machines
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP,
		TX_DONE
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_DELIVER
	} rx_state_t;

endpackage

//--- verilog/info_link_top.sv
// info link top level, transmit queue and PHY plus the receive PHY

module info_link_top (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  info_link_pkg::info_period_t tbit_period,
	input  logic                        push,
	input  info_link_pkg::info_byte_t   push_data,
	input  logic                        line_in,
	output logic                        full,
	output logic                        busy,
	output logic                        line_out,
	output info_link_pkg::info_byte_t   rx_data,
	output logic                        rx_valid,
	output logic                        rx_frame_err
);

	// queue to transmit PHY hand-off
	info_link_if link ();

	tx_byte_queue u_queue (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.push        (push),
		.push_data   (push_data),
		.tbit_period (tbit_period),
		.full        (full),
		.busy        (busy),
		.link        (link.queue)
	);

	tx_info_phy u_tx_phy (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.link    (link.phy),
		.tx      (line_out)
	);

	// separate line input, looped back on the board
	rx_info_phy u_rx_phy (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.rx           (line_in),
		.tbit_period  (tbit_period),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_frame_err (rx_frame_err)
	);

endmodule

//--- verilog/rx_info_phy.sv
// receive PHY, recovers one byte per frame and flags a low first stop bit

`include "info_link_params.svh"

module rx_info_phy (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        rx,
	input  info_link_pkg::info_period_t tbit_period,
	output info_link_pkg::info_byte_t   rx_data,
	output logic                        rx_valid,
	output logic                        rx_frame_err
);

	localparam int BIT_W = $clog2(`INFO_DATA_W);

	info_link_pkg::rx_state_t    state;
	info_link_pkg::info_period_t cnt_cycle;
	info_link_pkg::info_period_t half_period;
	info_link_pkg::info_byte_t   shift_q;
	logic [BIT_W-1:0]            bit_cnt;
	logic                        rx_meta;
	logic                        rx_sync;
	logic                        rx_prev;
	logic                        stop_ok;
	logic                        fall;
	logic                        bit_end;
	logic                        half_end;

	// ----------------------------------------------------------
	// line synchronizer and edge detect
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall = rx_prev && !rx_sync;

	assign half_period = tbit_period >> 1;
	assign half_end = (cnt_cycle == (half_period - info_link_pkg::info_period_t'(1)));
	assign bit_end = (cnt_cycle == (tbit_period - info_link_pkg::info_period_t'(1)));

	// ----------------------------------------------------------
	// receive FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state     <= info_link_pkg::RX_IDLE;
			cnt_cycle <= '0;
			bit_cnt   <= '0;
			stop_ok   <= 1'b1;
		end else begin
			cnt_cycle <= cnt_cycle + info_link_pkg::info_period_t'(1);
			case (state)
				info_link_pkg::RX_IDLE: begin
					cnt_cycle <= '0;
					if (fall) begin
						state <= info_link_pkg::RX_START;
					end
				end
				info_link_pkg::RX_START: begin
					if (half_end) begin
						cnt_cycle <= '0;
						bit_cnt   <= '0;
						// start bit gone by mid-bit, treat as a glitch
						state <= rx_sync ? info_link_pkg::RX_IDLE : info_link_pkg::RX_DATA;
					end
				end
				info_link_pkg::RX_DATA: begin
					if (bit_end) begin
						cnt_cycle <= '0;
						bit_cnt   <= bit_cnt + BIT_W'(1);
						if (bit_cnt == BIT_W'(`INFO_DATA_W - 1)) begin
							state <= info_link_pkg::RX_STOP;
						end
					end
				end
				info_link_pkg::RX_STOP: begin
					if (bit_end) begin
						cnt_cycle <= '0;
						stop_ok   <= rx_sync;
						state     <= info_link_pkg::RX_DELIVER;
					end
				end
				default: begin
					state <= info_link_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// data bits sampled mid-bit, MSB first
	always_ff @(posedge clk_sys) begin
		if ((state == info_link_pkg::RX_DATA) && bit_end) begin
			shift_q <= {shift_q[`INFO_DATA_W-2:0], rx_sync};
		end
	end

	assign rx_data      = shift_q;
	assign rx_valid     = (state == info_link_pkg::RX_DELIVER);
	assign rx_frame_err = rx_valid && !stop_ok;

endmodule

//--- verilog/tx_byte_queue.sv
// transmit byte FIFO, fires the PHY for each stored byte and waits for done

`include "info_link_params.svh"

module tx_byte_queue (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        push,
	input  info_link_pkg::info_byte_t   push_data,
	input  info_link_pkg::info_period_t tbit_period,
	output logic                        full,
	output logic                        busy,
	info_link_if.queue                  link
);

	localparam int AW = $clog2(`INFO_QUEUE_DEPTH);

	info_link_pkg::info_byte_t  mem [`INFO_QUEUE_DEPTH];
	info_link_pkg::queue_ptr_t  wr_ptr;
	info_link_pkg::queue_ptr_t  rd_ptr;
	logic                       outstanding;
	logic                       empty;
	logic                       do_push;
	logic                       do_pop;

	// ----------------------------------------------------------
	// occupancy
	// ----------------------------------------------------------
	assign empty = (wr_ptr == rd_ptr);
	// same index, wrapped a different number of times
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// pushes while full are dropped
	assign do_push = push && !full;
	// pop the head only when no frame is in flight
	assign do_pop = !empty && !outstanding;

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr[AW-1:0]] <= push_data;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + info_link_pkg::queue_ptr_t'(1);
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + info_link_pkg::queue_ptr_t'(1);
			end
		end
	end

	// set on fire, cleared by the PHY's done pulse
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			outstanding <= 1'b0;
		end else if (do_pop) begin
			outstanding <= 1'b1;
		end else if (link.done) begin
			outstanding <= 1'b0;
		end
	end

	// ----------------------------------------------------------
	// hand-off to the PHY
	// ----------------------------------------------------------
	assign link.fire   = do_pop;
	assign link.data   = mem[rd_ptr[AW-1:0]];
	assign link.period = tbit_period;

	assign busy = !empty || outstanding;

endmodule

//--- verilog/tx_info_phy.sv
// transmit PHY, serializes one byte MSB first with start and stop bits

`include "info_link_params.svh"

module tx_info_phy (
	input  logic      clk_sys,
	input  logic      rst_n,
	info_link_if.phy  link,
	output logic      tx
);

	localparam int BIT_W  = $clog2(`INFO_DATA_W);
	localparam int STOP_W = $clog2(`INFO_STOP_BITS);

	info_link_pkg::tx_state_t    state;
	info_link_pkg::info_byte_t   data_q;
	info_link_pkg::info_period_t cnt_cycle;
	logic [BIT_W-1:0]            bit_idx;
	logic [STOP_W-1:0]           stop_cnt;
	logic                        bit_end;
	logic                        sending;

	// payload latched on fire
	always_ff @(posedge clk_sys) begin
		if (link.fire) begin
			data_q <= link.data;
		end
	end

	// ----------------------------------------------------------
	// bit period counter
	// ----------------------------------------------------------
	assign sending = (state == info_link_pkg::TX_START) ||
		(state == info_link_pkg::TX_DATA) ||
		(state == info_link_pkg::TX_STOP);

	assign bit_end = (cnt_cycle == (link.period - info_link_pkg::info_period_t'(1)));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_cycle <= '0;
		end else if (!sending || bit_end) begin
			cnt_cycle <= '0;
		end else begin
			cnt_cycle <= cnt_cycle + info_link_pkg::info_period_t'(1);
		end
	end

	// ----------------------------------------------------------
	// main FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= info_link_pkg::TX_IDLE;
			bit_idx  <= '0;
			stop_cnt <= '0;
		end else begin
			case (state)
				info_link_pkg::TX_IDLE: begin
					if (link.fire) begin
						state <= info_link_pkg::TX_START;
					end
				end
				info_link_pkg::TX_START: begin
					if (bit_end) begin
						// MSB goes out first
						bit_idx <= BIT_W'(`INFO_DATA_W - 1);
						state   <= info_link_pkg::TX_DATA;
					end
				end
				info_link_pkg::TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx - BIT_W'(1);
						if (bit_idx == '0) begin
							stop_cnt <= '0;
							state    <= info_link_pkg::TX_STOP;
						end
					end
				end
				info_link_pkg::TX_STOP: begin
					if (bit_end) begin
						stop_cnt <= stop_cnt + STOP_W'(1);
						if (stop_cnt == STOP_W'(`INFO_STOP_BITS - 1)) begin
							state <= info_link_pkg::TX_DONE;
						end
					end
				end
				default: begin
					state <= info_link_pkg::TX_IDLE;
				end
			endcase
		end
	end

	assign link.done = (state == info_link_pkg::TX_DONE);

	// line idles high
	always_comb begin
		case (state)
			info_link_pkg::TX_START: tx = 1'b0;
			info_link_pkg::TX_DATA:  tx = data_q[bit_idx];
			default:                 tx = 1'b1;
		endcase
	end

endmodule
